/* hw/cache_geom_pkg.sv */
package cache_geom_pkg;

    // block and set geometry
    localparam int words_per_block = 4;
    localparam int num_sets        = 4;
    localparam int num_ways        = 2;

    // address split: tag | index | byte offset
    localparam int offset_bits = $clog2(words_per_block) + 2;
    localparam int index_bits  = $clog2(num_sets);
    localparam int tag_bits    = 32 - offset_bits - index_bits;
    localparam int block_bits  = words_per_block * 32;

    // address fields
    typedef logic [index_bits-1:0]       set_idx_t;
    typedef logic [$clog2(num_ways)-1:0] way_idx_t;
    typedef logic [tag_bits-1:0]         tag_t;

    // one whole block, word 0 in the low bits
    typedef logic [block_bits-1:0] block_t;

endpackage

/* hw/cache_msg_pkg.sv */
package cache_msg_pkg;

    import cache_geom_pkg::*;

    // per-line coherence state
    typedef enum logic [1:0] {ls_invalid, ls_shared, ls_modified} line_state_e;

    // controller FSM
    typedef enum logic [2:0] {s_idle, s_lookup, s_tx_evict, s_alloc_req, s_alloc_rx} ctrl_state_e;

    // core side request, byte address
    typedef struct packed {
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } core_req_t;

    // bus request, addr always block aligned
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        block_t      wdata;
    } bus_req_t;

    // state and tag of every way in the set that was read
    typedef struct packed {
        line_state_e [num_ways-1:0] state;
        tag_t [num_ways-1:0]        tag;
    } line_rd_t;

    // single write port into the line store
    typedef struct packed {
        logic        en;
        set_idx_t    set;
        way_idx_t    way;
        line_state_e state;
        tag_t        tag;
        block_t      data;
    } line_wr_t;

    // lookup outcome for the current request
    typedef struct packed {
        logic     miss;
        way_idx_t way;
        logic     victim_dirty;
        tag_t     victim_tag;
    } lookup_res_t;

endpackage

/* hw/cache_line_store.sv */
`timescale 1ns/1ps

module cache_line_store
    import cache_geom_pkg::*;
    import cache_msg_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   nreset_i,

    // registered set read
    input  logic                   rd_en_i,
    input  set_idx_t               rd_set_i,
    output line_rd_t               rd_line_o,
    output block_t [num_ways-1:0]  rd_data_o,

    // one line written per edge
    input  line_wr_t               wr_i
);

    // storage, indexed [set][way]
    line_state_e [num_sets-1:0][num_ways-1:0] state_r;
    tag_t [num_sets-1:0][num_ways-1:0]        tag_r;
    block_t [num_sets-1:0][num_ways-1:0]      data_r;

    // line state, cleared to invalid on reset
    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    state_r[s][w] <= ls_invalid;
                end
            end
        end else if (wr_i.en) begin
            state_r[wr_i.set][wr_i.way] <= wr_i.state;
        end
    end

    // tag and data follow the same write port
    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            tag_r[wr_i.set][wr_i.way]  <= wr_i.tag;
            data_r[wr_i.set][wr_i.way] <= wr_i.data;
        end
    end

    // whole set captured on the read strobe
    // held until the next request so evict and fill can use it
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_line_o.state <= state_r[rd_set_i];
            rd_line_o.tag   <= tag_r[rd_set_i];
            rd_data_o       <= data_r[rd_set_i];
        end
    end

    // tags only move when the controller writes a line
    a_tag_only_on_write: assert property (
        @(posedge clk_i) disable iff (nreset_i)
        !wr_i.en |=> tag_r === $past(tag_r)
    ) else $error("tag array changed without a write");

endmodule

/* hw/cache_way_lookup.sv */
`timescale 1ns/1ps

module cache_way_lookup
    import cache_geom_pkg::*;
    import cache_msg_pkg::*;
(
    input  logic        clk_i,
    input  logic        nreset_i,
    input  logic        lookup_i,
    input  tag_t        req_tag_i,
    input  line_rd_t    rd_line_i,
    output lookup_res_t res_o
);

    logic [num_ways-1:0] hit, invalid;
    way_idx_t hit_way, open_way, way_n, way_r, way_sel;
    logic any_hit, any_open;

    // per-way compare
    // walk from the top so the lowest matching way wins
    always_comb begin
        hit_way  = '0;
        open_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            invalid[w] = rd_line_i.state[w] == ls_invalid;
            hit[w]     = !invalid[w] && rd_line_i.tag[w] == req_tag_i;
            if (hit[w])
                hit_way = way_idx_t'(w);
            if (invalid[w])
                open_way = way_idx_t'(w);
        end
    end

    assign any_hit  = |hit;
    assign any_open = |invalid;

    // hit way, else a free way, else way 0 is evicted
    assign way_n = any_hit ? hit_way : (any_open ? open_way : '0);

    // way choice kept for evict, fill and hit write
    always_ff @(posedge clk_i) begin
        if (nreset_i)
            way_r <= '0;
        else if (lookup_i)
            way_r <= way_n;
    end

    assign way_sel = lookup_i ? way_n : way_r;

    assign res_o.miss         = !any_hit;
    assign res_o.way          = way_sel;
    // only a miss can push the chosen line out
    assign res_o.victim_dirty = !any_hit && rd_line_i.state[way_sel] == ls_modified;
    assign res_o.victim_tag   = rd_line_i.tag[way_sel];

    // chosen way must not drift while a miss is served
    a_way_held: assert property (
        @(posedge clk_i) disable iff (nreset_i)
        !lookup_i |-> $stable(res_o.way)
    ) else $error("way choice changed outside lookup");

endmodule

/* hw/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl
    import cache_geom_pkg::*;
    import cache_msg_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  nreset_i,
    // core port
    input  logic                  cc_valid_i,
    output logic                  cc_ready_o,
    input  core_req_t             cc_req_i,
    output logic                  cc_valid_o,
    output logic [31:0]           cc_rdata_o,
    // bus port
    output logic                  cb_valid_o,
    input  logic                  cb_yumi_i,
    output bus_req_t              cb_req_o,
    input  logic                  cb_valid_i,
    input  block_t                cb_data_i,
    // store and lookup
    output logic                  rd_en_o,
    output set_idx_t              rd_set_o,
    input  block_t [num_ways-1:0] rd_data_i,
    output tag_t                  req_tag_o,
    output logic                  lookup_o,
    input  lookup_res_t           res_i,
    output line_wr_t              wr_o
);

    ctrl_state_e state_r, state_n;
    core_req_t req_r;
    set_idx_t req_set;
    logic [offset_bits-3:0] word_idx;
    logic accept, hit, fill, evict;
    block_t src_blk, merged_blk;

    // replace enabled bytes of one word
    function automatic block_t merge_bytes(block_t blk, logic [offset_bits-3:0] word,
                                           logic [3:0] be, logic [31:0] wdata);
        block_t res;
        res = blk;
        for (int b = 0; b < 4; b++) begin
            if (be[b])
                res[word*32 + b*8 +: 8] = wdata[b*8 +: 8];
        end
        return res;
    endfunction

    // no hole between enabled bytes
    function automatic logic be_contig(logic [3:0] be);
        logic [3:0] low;
        low = be & (~be + 4'd1);
        return ((be + low) & be) == 4'd0;
    endfunction

    assign cc_ready_o = state_r == s_idle;
    assign accept     = cc_valid_i & cc_ready_o;

    // set read starts with the accept
    assign rd_en_o  = accept;
    assign rd_set_o = cc_req_i.addr[offset_bits +: index_bits];

    always_ff @(posedge clk_i) begin
        if (accept)
            req_r <= cc_req_i;
    end

    assign req_set   = req_r.addr[offset_bits +: index_bits];
    assign word_idx  = req_r.addr[offset_bits-1:2];
    assign req_tag_o = req_r.addr[31 -: tag_bits];
    assign lookup_o  = state_r == s_lookup;

    assign hit   = lookup_o & !res_i.miss;
    assign fill  = state_r == s_alloc_rx & cb_valid_i;
    assign evict = (lookup_o & res_i.miss & res_i.victim_dirty) | state_r == s_tx_evict;

    always_comb begin
        state_n = state_r;
        case (state_r)
            s_idle:      if (accept) state_n = s_lookup;
            // bus request already offered in lookup, yumi may skip a state
            s_lookup: begin
                if (!res_i.miss)
                    state_n = s_idle;
                else if (res_i.victim_dirty)
                    state_n = cb_yumi_i ? s_alloc_req : s_tx_evict;
                else
                    state_n = cb_yumi_i ? s_alloc_rx : s_alloc_req;
            end
            s_tx_evict:  if (cb_yumi_i) state_n = s_alloc_req;
            s_alloc_req: if (cb_yumi_i) state_n = s_alloc_rx;
            s_alloc_rx:  if (cb_valid_i) state_n = s_idle;
            default:     state_n = s_idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i)
            state_r <= s_idle;
        else
            state_r <= state_n;
    end

    // fill block during alloc_rx, stored block otherwise
    assign src_blk    = (state_r == s_alloc_rx) ? cb_data_i : rd_data_i[res_i.way];
    assign merged_blk = req_r.we ? merge_bytes(src_blk, word_idx, req_r.be, req_r.wdata)
                                 : src_blk;

    // hit write or fill
    assign wr_o.en    = fill | (hit & req_r.we);
    assign wr_o.set   = req_set;
    assign wr_o.way   = res_i.way;
    assign wr_o.state = req_r.we ? ls_modified : ls_shared;
    assign wr_o.tag   = req_tag_o;
    assign wr_o.data  = merged_blk;

    // eviction first, then the allocate read
    assign cb_valid_o     = (lookup_o & res_i.miss) | state_r == s_tx_evict
                          | state_r == s_alloc_req;
    assign cb_req_o.we    = evict;
    assign cb_req_o.addr  = evict ? {res_i.victim_tag, req_set, offset_bits'(0)}
                                  : {req_r.addr[31:offset_bits], offset_bits'(0)};
    assign cb_req_o.wdata = evict ? rd_data_i[res_i.way] : '0;

    // response, writes return zero
    assign cc_valid_o = hit | fill;
    assign cc_rdata_o = req_r.we ? 32'd0 : src_blk[word_idx*32 +: 32];

    a_lookup_one_cycle: assert property (
        @(posedge clk_i) disable iff (nreset_i)
        state_r == s_lookup |=> state_r != s_lookup
    ) else $error("lookup held for more than one cycle");

    a_fill_in_alloc_rx: assert property (
        @(posedge clk_i) disable iff (nreset_i)
        cb_valid_i |-> state_r == s_alloc_rx
    ) else $error("bus data outside alloc_rx");

    a_be_contiguous: assert property (
        @(posedge clk_i) disable iff (nreset_i)
        accept & cc_req_i.we |-> be_contig(cc_req_i.be)
    ) else $error("write byte enables not contiguous");

endmodule

/* hw/cache_top.sv */
`timescale 1ns/1ps

module cache_top
    import cache_geom_pkg::*;
    import cache_msg_pkg::*;
(
    input  logic        clk_i,
    input  logic        nreset_i,
    input  logic        cc_valid_i,
    output logic        cc_ready_o,
    input  core_req_t   cc_req_i,
    output logic        cc_valid_o,
    output logic [31:0] cc_rdata_o,
    output logic        cb_valid_o,
    input  logic        cb_yumi_i,
    output bus_req_t    cb_req_o,
    input  logic        cb_valid_i,
    input  block_t      cb_data_i
);

    // store read and write
    logic                  rd_en;
    set_idx_t              rd_set;
    line_rd_t              rd_line;
    block_t [num_ways-1:0] rd_data;
    line_wr_t              wr;

    // lookup handshake
    tag_t        req_tag;
    logic        lookup;
    lookup_res_t res;

    cache_line_store u_store (
        .clk_i     (clk_i),
        .nreset_i  (nreset_i),
        .rd_en_i   (rd_en),
        .rd_set_i  (rd_set),
        .rd_line_o (rd_line),
        .rd_data_o (rd_data),
        .wr_i      (wr)
    );

    cache_way_lookup u_lookup (
        .clk_i     (clk_i),
        .nreset_i  (nreset_i),
        .lookup_i  (lookup),
        .req_tag_i (req_tag),
        .rd_line_i (rd_line),
        .res_o     (res)
    );

    cache_ctrl u_ctrl (
        .clk_i      (clk_i),
        .nreset_i   (nreset_i),
        .cc_valid_i (cc_valid_i),
        .cc_ready_o (cc_ready_o),
        .cc_req_i   (cc_req_i),
        .cc_valid_o (cc_valid_o),
        .cc_rdata_o (cc_rdata_o),
        .cb_valid_o (cb_valid_o),
        .cb_yumi_i  (cb_yumi_i),
        .cb_req_o   (cb_req_o),
        .cb_valid_i (cb_valid_i),
        .cb_data_i  (cb_data_i),
        .rd_en_o    (rd_en),
        .rd_set_o   (rd_set),
        .rd_data_i  (rd_data),
        .req_tag_o  (req_tag),
        .lookup_o   (lookup),
        .res_i      (res),
        .wr_o       (wr)
    );

endmodule

/* bench/cache_mem_model.sv */
`timescale 1ns/1ps

module cache_mem_model
    import cache_geom_pkg::*;
    import cache_msg_pkg::*;
(
    input  logic     clk_i,
    input  logic     nreset_i,
    // request side, offered by the cache
    input  logic     req_valid_i,
    input  bus_req_t req_i,
    output logic     yumi_o,
    // fill side
    output logic     data_valid_o,
    output block_t   data_o
);

    // cycles a request waits for yumi, and yumi to fill data
    localparam int accept_delay = 2;
    localparam int data_delay   = 3;

    // backing store keyed by block address, pattern until first write
    block_t mem_r [logic [31:0]];

    logic   yumi_r       = 1'b0;
    logic   data_valid_r = 1'b0;
    block_t data_r       = '0;
    logic   pending_r    = 1'b0;
    block_t pending_blk  = '0;
    int     wait_cnt     = 0;
    int     data_cnt     = 0;

    // each word starts as its own address xor a fixed pattern
    function automatic block_t read_block(logic [31:0] addr);
        block_t blk;
        if (mem_r.exists(addr)) begin
            blk = mem_r[addr];
        end else begin
            for (int w = 0; w < words_per_block; w++) begin
                blk[w*32 +: 32] = (addr + 32'(w * 4)) ^ 32'hA5A5_0000;
            end
        end
        return blk;
    endfunction

    // responses change on the falling edge
    always @(negedge clk_i) begin
        yumi_r       <= 1'b0;
        data_valid_r <= 1'b0;
        if (nreset_i) begin
            pending_r <= 1'b0;
            wait_cnt  <= 0;
            data_cnt  <= 0;
        end else if (pending_r) begin
            // one read in flight, count down to the fill beat
            if (data_cnt == 1) begin
                data_valid_r <= 1'b1;
                data_r       <= pending_blk;
                pending_r    <= 1'b0;
            end else begin
                data_cnt <= data_cnt - 1;
            end
        end else if (req_valid_i && !yumi_r) begin
            if (wait_cnt == accept_delay - 1) begin
                yumi_r   <= 1'b1;
                wait_cnt <= 0;
                // write-back lands now, read data comes later
                if (req_i.we) begin
                    mem_r[req_i.addr] = req_i.wdata;
                end else begin
                    pending_r   <= 1'b1;
                    pending_blk <= read_block(req_i.addr);
                    data_cnt    <= data_delay;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

    assign yumi_o       = yumi_r;
    assign data_valid_o = data_valid_r;
    assign data_o       = data_r;

endmodule

/* bench/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb
    import cache_geom_pkg::*;
    import cache_msg_pkg::*;
();

    localparam int reset_cycles       = 4;
    // requests issued over all tests, sets the watchdog budget
    localparam int num_requests       = 16;
    localparam int cycles_per_request = 200;

    logic        clk = 1'b0;
    logic        nreset;
    logic        cc_valid;
    logic        cc_ready;
    core_req_t   cc_req;
    logic        cc_resp_valid;
    logic [31:0] cc_rdata;
    logic        cb_valid;
    logic        cb_yumi;
    bus_req_t    cb_req;
    logic        cb_fill_valid;
    block_t      cb_data;

    int error_count     = 0;
    int check_count     = 0;
    int bus_busy_cycles = 0;

    // captured responses and accepted bus packets
    logic [31:0] resp_q[$];
    bus_req_t    bus_q[$];

    // expected memory contents, word granular
    logic [31:0] shadow_mem [logic [31:0]];

    logic [31:0]         lcg_state = 32'd49;
    logic [num_sets-1:0] set_used  = '0;
    // block cached by the first test
    logic [31:0]         base_addr = '0;

    always #5 clk = ~clk;

    cache_top u_cache_top (
        .clk_i      (clk),
        .nreset_i   (nreset),
        .cc_valid_i (cc_valid),
        .cc_ready_o (cc_ready),
        .cc_req_i   (cc_req),
        .cc_valid_o (cc_resp_valid),
        .cc_rdata_o (cc_rdata),
        .cb_valid_o (cb_valid),
        .cb_yumi_i  (cb_yumi),
        .cb_req_o   (cb_req),
        .cb_valid_i (cb_fill_valid),
        .cb_data_i  (cb_data)
    );

    cache_mem_model u_mem (
        .clk_i        (clk),
        .nreset_i     (nreset),
        .req_valid_i  (cb_valid),
        .req_i        (cb_req),
        .yumi_o       (cb_yumi),
        .data_valid_o (cb_fill_valid),
        .data_o       (cb_data)
    );

    // responses and bus handshakes seen at the rising edge
    always @(posedge clk) begin
        if (!nreset) begin
            if (cc_resp_valid)
                resp_q.push_back(cc_rdata);
            if (cb_valid)
                bus_busy_cycles++;
            if (cb_valid && cb_yumi)
                bus_q.push_back(cb_req);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] random_word_addr();
        logic [31:0] r;
        r = lcg_next();
        return {r[31:2], 2'b00};
    endfunction

    function automatic logic [31:0] random_addr_in_set(set_idx_t s);
        logic [31:0] addr;
        addr = random_word_addr();
        addr[offset_bits +: index_bits] = s;
        return addr;
    endfunction

    function automatic logic [31:0] block_addr(logic [31:0] addr);
        logic [31:0] ba;
        ba = addr;
        ba[offset_bits-1:0] = '0;
        return ba;
    endfunction

    // untouched words keep the reset pattern of memory
    function automatic logic [31:0] shadow_rd(logic [31:0] addr);
        logic [31:0] waddr;
        logic [31:0] word;
        waddr = {addr[31:2], 2'b00};
        if (shadow_mem.exists(waddr))
            word = shadow_mem[waddr];
        else
            word = waddr ^ 32'hA5A5_0000;
        return word;
    endfunction

    function automatic block_t shadow_block(logic [31:0] addr);
        block_t blk;
        logic [31:0] base;
        base = block_addr(addr);
        for (int w = 0; w < words_per_block; w++) begin
            blk[w*32 +: 32] = shadow_rd(base + 32'(w * 4));
        end
        return blk;
    endfunction

    // only contiguous lane patterns
    function automatic logic [3:0] pick_be();
        logic [31:0] r;
        logic [3:0] be;
        r = lcg_next();
        case (r[3:0])
            4'd0:    be = 4'b0001;
            4'd1:    be = 4'b0010;
            4'd2:    be = 4'b0100;
            4'd3:    be = 4'b1000;
            4'd4:    be = 4'b0011;
            4'd5:    be = 4'b0110;
            4'd6:    be = 4'b1100;
            4'd7:    be = 4'b0111;
            4'd8:    be = 4'b1110;
            default: be = 4'b1111;
        endcase
        return be;
    endfunction

    task automatic shadow_wr(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        shadow_mem[{addr[31:2], 2'b00}] = (shadow_rd(addr) & ~mask) | (wdata & mask);
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        nreset = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        nreset = 1'b0;
    endtask

    // one request, returns once the response pulse was captured
    task automatic issue_req(input logic we, input logic [3:0] be, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int n_resp;
        @(negedge clk);
        while (!cc_ready)
            @(negedge clk);
        n_resp = resp_q.size();
        cc_req.we    = we;
        cc_req.be    = be;
        cc_req.addr  = addr;
        cc_req.wdata = wdata;
        cc_valid     = 1'b1;
        @(negedge clk);
        cc_valid = 1'b0;
        while (resp_q.size() == n_resp)
            @(negedge clk);
        rdata = resp_q[n_resp];
        set_used[addr[offset_bits +: index_bits]] = 1'b1;
    endtask

    task automatic test_read_miss();
        logic [31:0] addr;
        logic [31:0] rdata;
        bus_req_t    pkt;
        int          n_bus;
        addr  = random_word_addr();
        n_bus = bus_q.size();
        issue_req(1'b0, 4'h0, addr, 32'd0, rdata);
        check_value("read_miss data", 128'(shadow_rd(addr)), 128'(rdata));
        check_value("read_miss bus count", 128'(1), 128'(bus_q.size() - n_bus));
        if (bus_q.size() > n_bus) begin
            pkt = bus_q[n_bus];
            check_value("read_miss bus we", 128'(0), 128'(pkt.we));
            check_value("read_miss bus addr", 128'(block_addr(addr)), 128'(pkt.addr));
        end
        base_addr = addr;
    endtask

    // every word of the cached block, bus stays quiet
    task automatic test_read_hit();
        logic [31:0] addr;
        logic [31:0] rdata;
        int          busy0;
        for (int w = 0; w < words_per_block; w++) begin
            addr  = block_addr(base_addr) + 32'(w * 4);
            busy0 = bus_busy_cycles;
            issue_req(1'b0, 4'h0, addr, 32'd0, rdata);
            check_value("read_hit data", 128'(shadow_rd(addr)), 128'(rdata));
            check_value("read_hit bus cycles", 128'(0), 128'(bus_busy_cycles - busy0));
            check_value("read_hit ready", 128'(1), 128'(cc_ready));
        end
    endtask

    task automatic test_hit_write();
        logic [31:0] addr;
        logic [31:0] r;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [3:0]  be;
        int          busy0;
        r     = lcg_next();
        addr  = block_addr(base_addr);
        addr[offset_bits-1:2] = r[offset_bits-3:0];
        be    = pick_be();
        wdata = lcg_next();
        busy0 = bus_busy_cycles;
        issue_req(1'b1, be, addr, wdata, rdata);
        shadow_wr(addr, be, wdata);
        check_value("hit_write resp", 128'(0), 128'(rdata));
        check_value("hit_write bus cycles", 128'(0), 128'(bus_busy_cycles - busy0));
        issue_req(1'b0, 4'h0, addr, 32'd0, rdata);
        check_value("hit_write readback", 128'(shadow_rd(addr)), 128'(rdata));
    endtask

    // fill block merged with the write lanes
    task automatic test_write_miss();
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [3:0]  be;
        bus_req_t    pkt;
        int          n_bus;
        do begin
            addr = random_word_addr();
        end while (block_addr(addr) == block_addr(base_addr));
        be    = pick_be();
        wdata = lcg_next();
        n_bus = bus_q.size();
        issue_req(1'b1, be, addr, wdata, rdata);
        shadow_wr(addr, be, wdata);
        check_value("write_miss resp", 128'(0), 128'(rdata));
        check_value("write_miss bus count", 128'(1), 128'(bus_q.size() - n_bus));
        if (bus_q.size() > n_bus) begin
            pkt = bus_q[n_bus];
            check_value("write_miss bus we", 128'(0), 128'(pkt.we));
            check_value("write_miss bus addr", 128'(block_addr(addr)), 128'(pkt.addr));
        end
        issue_req(1'b0, 4'h0, addr, 32'd0, rdata);
        check_value("write_miss readback", 128'(shadow_rd(addr)), 128'(rdata));
    endtask

    task automatic test_evict();
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        logic [31:0] addr_c;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [3:0]  be;
        set_idx_t    s;
        logic        found;
        bus_req_t    wb_pkt;
        bus_req_t    rd_pkt;
        int          n_bus;
        // a set no earlier test touched, so both ways start invalid
        found = 1'b0;
        s     = '0;
        for (int i = num_sets - 1; i >= 0; i--) begin
            if (!set_used[i]) begin
                s     = set_idx_t'(i);
                found = 1'b1;
            end
        end
        if (!found) begin
            error_count++;
            $display("eviction test found no untouched set to start from");
        end
        addr_a = random_addr_in_set(s);
        do begin
            addr_b = random_addr_in_set(s);
        end while (block_addr(addr_b) == block_addr(addr_a));
        do begin
            addr_c = random_addr_in_set(s);
        end while (block_addr(addr_c) == block_addr(addr_a) ||
                   block_addr(addr_c) == block_addr(addr_b));
        // a lands in way 0, b in way 1
        issue_req(1'b0, 4'h0, addr_a, 32'd0, rdata);
        check_value("evict fill a", 128'(shadow_rd(addr_a)), 128'(rdata));
        issue_req(1'b0, 4'h0, addr_b, 32'd0, rdata);
        check_value("evict fill b", 128'(shadow_rd(addr_b)), 128'(rdata));
        // way 0 goes modified
        be    = pick_be();
        wdata = lcg_next();
        issue_req(1'b1, be, addr_a, wdata, rdata);
        shadow_wr(addr_a, be, wdata);
        check_value("evict write a resp", 128'(0), 128'(rdata));
        // full set, c pushes out way 0
        n_bus = bus_q.size();
        issue_req(1'b0, 4'h0, addr_c, 32'd0, rdata);
        check_value("evict read c", 128'(shadow_rd(addr_c)), 128'(rdata));
        check_value("evict bus count", 128'(2), 128'(bus_q.size() - n_bus));
        if (bus_q.size() >= n_bus + 2) begin
            wb_pkt = bus_q[n_bus];
            rd_pkt = bus_q[n_bus + 1];
            check_value("evict wb we", 128'(1), 128'(wb_pkt.we));
            check_value("evict wb addr", 128'(block_addr(addr_a)), 128'(wb_pkt.addr));
            check_value("evict wb data", 128'(shadow_block(addr_a)), 128'(wb_pkt.wdata));
            check_value("evict alloc we", 128'(0), 128'(rd_pkt.we));
            check_value("evict alloc addr", 128'(block_addr(addr_c)), 128'(rd_pkt.addr));
        end
        // a comes back from memory with the written word
        n_bus = bus_q.size();
        issue_req(1'b0, 4'h0, addr_a, 32'd0, rdata);
        check_value("evict refill a", 128'(shadow_rd(addr_a)), 128'(rdata));
        check_value("evict refill bus count", 128'(1), 128'(bus_q.size() - n_bus));
        if (bus_q.size() > n_bus) begin
            rd_pkt = bus_q[n_bus];
            check_value("evict refill we", 128'(0), 128'(rd_pkt.we));
            check_value("evict refill addr", 128'(block_addr(addr_a)), 128'(rd_pkt.addr));
        end
    endtask

    // reset drops the line, the same read goes to the bus again
    task automatic test_reset_refill();
        logic [31:0] addr;
        logic [31:0] rdata;
        bus_req_t    pkt;
        int          n_bus;
        addr = random_word_addr();
        issue_req(1'b0, 4'h0, addr, 32'd0, rdata);
        check_value("reset first read", 128'(shadow_rd(addr)), 128'(rdata));
        apply_reset();
        n_bus = bus_q.size();
        issue_req(1'b0, 4'h0, addr, 32'd0, rdata);
        check_value("reset reread bus count", 128'(1), 128'(bus_q.size() - n_bus));
        if (bus_q.size() > n_bus) begin
            pkt = bus_q[n_bus];
            check_value("reset reread we", 128'(0), 128'(pkt.we));
            check_value("reset reread addr", 128'(block_addr(addr)), 128'(pkt.addr));
        end
        check_value("reset reread data", 128'(shadow_rd(addr)), 128'(rdata));
    endtask

    initial begin
        nreset   = 1'b1;
        cc_valid = 1'b0;
        cc_req   = '0;
        apply_reset();
        test_read_miss();
        test_read_hit();
        test_hit_write();
        test_write_miss();
        test_evict();
        test_reset_refill();
        @(negedge clk);
        $display("checks run %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // budget per request plus both reset phases
    initial begin
        repeat (num_requests * cycles_per_request + 4 * reset_cycles) @(posedge clk);
        $display("watchdog expired, the cache stopped answering requests");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* compile.f */
hw/cache_geom_pkg.sv
hw/cache_msg_pkg.sv
hw/cache_line_store.sv
hw/cache_way_lookup.sv
hw/cache_ctrl.sv
hw/cache_top.sv
bench/cache_mem_model.sv
bench/cache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert -sv -f compile.f --top-module cache_tb \
    -Mdir "$build_dir" -o cache_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/cache_tb_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTS FAILED" "$log_file"; then
    echo "testbench reported a failure, see $log_file"
    exit 1
fi
if ! grep -q "TESTS PASSED" "$log_file"; then
    echo "no final result in $log_file"
    exit 1
fi
exit 0
